// File: src/memcopy_pkg.sv
// Memory-copy subsystem shared definitions
// Sizes, register map, status bits and the copy engine state type
`default_nettype none

package memcopy_pkg;

  // Bus and memory sizes
  localparam int DATA_W           = 32;
  localparam int MEM_WORDS        = 128;
  localparam int MEM_AW           = 7;
  localparam int REG_AW           = 4;
  localparam int SLOW_MEM_LATENCY = 3;

  // Register byte offsets, CTRL on write and STATUS on read share one slot
  localparam logic [REG_AW-1:0] REG_SRC    = 4'h0;
  localparam logic [REG_AW-1:0] REG_DST    = 4'h4;
  localparam logic [REG_AW-1:0] REG_LEN    = 4'h8;
  localparam logic [REG_AW-1:0] REG_CTRL   = 4'hC;
  localparam logic [REG_AW-1:0] REG_STATUS = 4'hC;

  // Status word bits
  localparam int STATUS_BUSY = 0;
  localparam int STATUS_DONE = 1;

  typedef enum logic [2:0] {
    IDLE,
    RD_REQ,
    RD_WAIT,
    WR_REQ,
    WR_WAIT,
    FINISH
  } copy_state_e;

endpackage

`default_nettype wire

// File: src/obi_bus_if.sv
// OBI request/grant/rvalid bundle
// Master drives the request side, slave answers with gnt, rvalid and rdata
`default_nettype none

interface obi_bus_if
  import memcopy_pkg::*;
();

  logic                  req;
  logic                  we;
  logic [DATA_W/8-1:0]   be;
  logic [DATA_W-1:0]     addr;
  logic [DATA_W-1:0]     wdata;
  logic                  gnt;
  logic                  rvalid;
  logic [DATA_W-1:0]     rdata;

  modport master (
    output req, we, be, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport slave (
    input  req, we, be, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

`default_nettype wire

// File: src/copy_counter.sv
// Word index counter for the copy engine
// Tracks the current index and the words still to copy
`default_nettype none

module copy_counter
  import memcopy_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire logic              load_i,
  input  wire logic [DATA_W-1:0] len_i,
  input  wire logic              advance_i,
  output logic      [DATA_W-1:0] index_o,
  output logic                   last_o,
  output logic                   empty_o
);

  logic [DATA_W-1:0] remain_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      index_o  <= '0;
      remain_q <= '0;
    end else if (load_i) begin
      index_o  <= '0;
      remain_q <= len_i;
    end else if (advance_i) begin
      index_o  <= index_o + 1'b1;
      remain_q <= remain_q - 1'b1;
    end
  end

  assign last_o  = (remain_q == DATA_W'(1));
  assign empty_o = (len_i == '0);

endmodule

`default_nettype wire

// File: src/memcopy_regs.sv
// Memory-copy register slave
// Holds source, destination and length, issues start, tracks busy and done
`default_nettype none

module memcopy_regs
  import memcopy_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire logic              reg_valid_i,
  input  wire logic              reg_write_i,
  input  wire logic [REG_AW-1:0] reg_addr_i,
  input  wire logic [DATA_W-1:0] reg_wdata_i,
  output logic      [DATA_W-1:0] reg_rdata_o,
  output logic                   reg_ready_o,
  output logic                   start_o,
  output logic      [DATA_W-1:0] src_addr_o,
  output logic      [DATA_W-1:0] dst_addr_o,
  output logic      [DATA_W-1:0] len_o,
  input  wire logic              done_i,
  output logic                   intr_o
);

  logic              access;
  logic              busy_q;
  logic              done_q;
  logic [DATA_W-1:0] status;

  // One access per valid, ready answers the following cycle
  assign access = reg_valid_i && !reg_ready_o;

  always_comb begin
    status              = '0;
    status[STATUS_BUSY] = busy_q;
    status[STATUS_DONE] = done_q;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reg_ready_o <= 1'b0;
      reg_rdata_o <= '0;
      start_o     <= 1'b0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      src_addr_o  <= '0;
      dst_addr_o  <= '0;
      len_o       <= '0;
    end else begin
      reg_ready_o <= access;
      start_o     <= 1'b0;
      if (access && reg_write_i && !busy_q) begin
        case (reg_addr_i)
          REG_SRC: src_addr_o <= reg_wdata_i;
          REG_DST: dst_addr_o <= reg_wdata_i;
          REG_LEN: len_o      <= reg_wdata_i;
          REG_CTRL: begin
            if (reg_wdata_i[0]) begin
              start_o <= 1'b1;
              busy_q  <= 1'b1;
              done_q  <= 1'b0;
            end
          end
          default: ;
        endcase
      end
      if (access && !reg_write_i) begin
        case (reg_addr_i)
          REG_SRC: reg_rdata_o <= src_addr_o;
          REG_DST: reg_rdata_o <= dst_addr_o;
          REG_LEN: reg_rdata_o <= len_o;
          REG_STATUS: begin
            reg_rdata_o <= status;
            done_q      <= 1'b0;
          end
          default: reg_rdata_o <= '0;
        endcase
      end
      // Completion wins over a status read in the same cycle
      if (done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  assign intr_o = done_q;

endmodule

`default_nettype wire

// File: src/memcopy_fsm.sv
// Copy engine
// Reads each source word and writes it to the destination over OBI
`default_nettype none

module memcopy_fsm
  import memcopy_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire logic              start_i,
  input  wire logic [DATA_W-1:0] src_addr_i,
  input  wire logic [DATA_W-1:0] dst_addr_i,
  input  wire logic [DATA_W-1:0] len_i,
  output logic                   done_o,
  obi_bus_if.master              bus
);

  copy_state_e       state_q;
  copy_state_e       state_d;
  logic [DATA_W-1:0] data_q;
  logic [DATA_W-1:0] index;
  logic [DATA_W-1:0] offset;
  logic              load;
  logic              advance;
  logic              last;
  logic              empty;

  copy_counter u_counter (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .load_i    (load),
    .len_i     (len_i),
    .advance_i (advance),
    .index_o   (index),
    .last_o    (last),
    .empty_o   (empty)
  );

  // Word index to byte offset
  assign offset = {index[DATA_W-3:0], 2'b00};

  always_comb begin
    state_d = state_q;
    load    = 1'b0;
    advance = 1'b0;
    done_o  = 1'b0;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          load    = 1'b1;
          state_d = empty ? FINISH : RD_REQ;
        end
      end
      RD_REQ: begin
        if (bus.gnt) state_d = RD_WAIT;
      end
      RD_WAIT: begin
        if (bus.rvalid) state_d = WR_REQ;
      end
      WR_REQ: begin
        if (bus.gnt) state_d = WR_WAIT;
      end
      WR_WAIT: begin
        if (bus.rvalid) begin
          advance = 1'b1;
          state_d = last ? FINISH : RD_REQ;
        end
      end
      FINISH: begin
        done_o  = 1'b1;
        state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Read data held for the write phase
  always_ff @(posedge clk_i) begin
    if (state_q == RD_WAIT && bus.rvalid) begin
      data_q <= bus.rdata;
    end
  end

  // Request payload stays steady while waiting for gnt
  assign bus.req   = (state_q == RD_REQ) || (state_q == WR_REQ);
  assign bus.we    = (state_q == WR_REQ);
  assign bus.be    = '1;
  assign bus.addr  = (state_q == WR_REQ) ? dst_addr_i + offset : src_addr_i + offset;
  assign bus.wdata = data_q;

endmodule

`default_nettype wire

// File: src/obi_arbiter.sv
// Two-master fixed-priority OBI arbiter
// hi_bus wins a tie, the granted master owns the response path
`default_nettype none

module obi_arbiter
  import memcopy_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic reset_i,
  obi_bus_if.slave  hi_bus,
  obi_bus_if.slave  lo_bus,
  obi_bus_if.master mem_bus
);

  logic sel_lo;
  logic owner_lo_q;

  // Low side only when the high side is quiet
  assign sel_lo = !hi_bus.req;

  assign mem_bus.req   = hi_bus.req || lo_bus.req;
  assign mem_bus.we    = sel_lo ? lo_bus.we    : hi_bus.we;
  assign mem_bus.be    = sel_lo ? lo_bus.be    : hi_bus.be;
  assign mem_bus.addr  = sel_lo ? lo_bus.addr  : hi_bus.addr;
  assign mem_bus.wdata = sel_lo ? lo_bus.wdata : hi_bus.wdata;

  assign hi_bus.gnt = mem_bus.gnt && !sel_lo;
  assign lo_bus.gnt = mem_bus.gnt && sel_lo;

  // Owner latched at grant, response follows one cycle later
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owner_lo_q <= 1'b0;
    end else if (mem_bus.gnt) begin
      owner_lo_q <= sel_lo;
    end
  end

  assign hi_bus.rvalid = mem_bus.rvalid && !owner_lo_q;
  assign lo_bus.rvalid = mem_bus.rvalid && owner_lo_q;
  assign hi_bus.rdata  = owner_lo_q ? '0 : mem_bus.rdata;
  assign lo_bus.rdata  = owner_lo_q ? mem_bus.rdata : '0;

endmodule

`default_nettype wire

// File: src/slow_memory.sv
// Slow word RAM on an OBI slave port
// Grants after a fixed wait, read data and rvalid are registered
`default_nettype none

module slow_memory
  import memcopy_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic reset_i,
  obi_bus_if.slave  bus
);

  logic [DATA_W-1:0]                       mem [MEM_WORDS];
  logic [$clog2(SLOW_MEM_LATENCY+1)-1:0]   wait_q;
  logic [MEM_AW-1:0]                       word_idx;
  logic                                    rvalid_q;
  logic [DATA_W-1:0]                       rdata_q;

  assign word_idx = bus.addr[MEM_AW+1:2];

  // Grant once the request has waited the full latency
  assign bus.gnt = bus.req && (wait_q == SLOW_MEM_LATENCY);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wait_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.gnt;
      if (!bus.req || bus.gnt) begin
        wait_q <= '0;
      end else begin
        wait_q <= wait_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.gnt) begin
      if (bus.we) begin
        for (int b = 0; b < DATA_W / 8; b++) begin
          if (bus.be[b]) mem[word_idx][8*b+:8] <= bus.wdata[8*b+:8];
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

endmodule

`default_nettype wire

// File: src/memcopy_subsystem.sv
// Memory-copy subsystem top level
// Register slave, copy engine and external port sharing one slow RAM
`default_nettype none

module memcopy_subsystem
  import memcopy_pkg::*;
(
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire logic                reg_valid_i,
  input  wire logic                reg_write_i,
  input  wire logic [REG_AW-1:0]   reg_addr_i,
  input  wire logic [DATA_W-1:0]   reg_wdata_i,
  output logic      [DATA_W-1:0]   reg_rdata_o,
  output logic                     reg_ready_o,
  input  wire logic                mem_req_i,
  input  wire logic                mem_we_i,
  input  wire logic [DATA_W/8-1:0] mem_be_i,
  input  wire logic [DATA_W-1:0]   mem_addr_i,
  input  wire logic [DATA_W-1:0]   mem_wdata_i,
  output logic                     mem_gnt_o,
  output logic                     mem_rvalid_o,
  output logic      [DATA_W-1:0]   mem_rdata_o,
  output logic                     copy_intr_o
);

  logic              start;
  logic              done;
  logic [DATA_W-1:0] src_addr;
  logic [DATA_W-1:0] dst_addr;
  logic [DATA_W-1:0] len;

  obi_bus_if copy_bus ();
  obi_bus_if ext_bus ();
  obi_bus_if mem_bus ();

  // External port onto the low-priority side
  assign ext_bus.req   = mem_req_i;
  assign ext_bus.we    = mem_we_i;
  assign ext_bus.be    = mem_be_i;
  assign ext_bus.addr  = mem_addr_i;
  assign ext_bus.wdata = mem_wdata_i;
  assign mem_gnt_o     = ext_bus.gnt;
  assign mem_rvalid_o  = ext_bus.rvalid;
  assign mem_rdata_o   = ext_bus.rdata;

  memcopy_regs u_regs (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ready_o (reg_ready_o),
    .start_o     (start),
    .src_addr_o  (src_addr),
    .dst_addr_o  (dst_addr),
    .len_o       (len),
    .done_i      (done),
    .intr_o      (copy_intr_o)
  );

  memcopy_fsm u_fsm (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .start_i    (start),
    .src_addr_i (src_addr),
    .dst_addr_i (dst_addr),
    .len_i      (len),
    .done_o     (done),
    .bus        (copy_bus)
  );

  obi_arbiter u_arbiter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .hi_bus  (copy_bus),
    .lo_bus  (ext_bus),
    .mem_bus (mem_bus)
  );

  slow_memory u_memory (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .bus     (mem_bus)
  );

endmodule

`default_nettype wire

// File: tb/memcopy_subsystem_checker.sv
// Bound assertions for the memory-copy subsystem
// External OBI handshake, interrupt against engine state, reset values
`default_nettype none

module memcopy_subsystem_checker
  import memcopy_pkg::*;
(
  input wire logic        clk_i,
  input wire logic        reset_i,
  input wire logic        mem_req_i,
  input wire logic        mem_gnt_i,
  input wire logic        mem_rvalid_i,
  input wire logic        reg_ready_i,
  input wire logic        copy_intr_i,
  input wire copy_state_e state_i
);
  timeunit 1ns;
  timeprecision 1ps;

  assert property (@(posedge clk_i) disable iff (reset_i) mem_gnt_i |-> mem_req_i)
    else $error("external grant seen without a request");

  assert property (@(posedge clk_i) disable iff (reset_i) mem_gnt_i |=> mem_rvalid_i)
    else $error("external response missing one cycle after grant");

  assert property (@(posedge clk_i) disable iff (reset_i) mem_rvalid_i |-> $past(mem_gnt_i))
    else $error("external response without a grant in the cycle before");

  // Done is only reported once the engine has returned to idle
  assert property (@(posedge clk_i) disable iff (reset_i) copy_intr_i |-> state_i == IDLE)
    else $error("copy interrupt high while the engine is active");

  assert property (@(posedge clk_i)
    reset_i |=> !(reg_ready_i || mem_gnt_i || mem_rvalid_i || copy_intr_i))
    else $error("output high in the cycle after reset");

endmodule

bind memcopy_subsystem memcopy_subsystem_checker u_checker (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .mem_req_i    (mem_req_i),
  .mem_gnt_i    (mem_gnt_o),
  .mem_rvalid_i (mem_rvalid_o),
  .reg_ready_i  (reg_ready_o),
  .copy_intr_i  (copy_intr_o),
  .state_i      (u_fsm.state_q)
);

`default_nettype wire

// File: tb/memcopy_subsystem_tb.sv
// Testbench for the memory-copy subsystem
// Preloads the RAM, runs a table of copies and checks against a shadow model
`default_nettype none

module memcopy_subsystem_tb
  import memcopy_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int         TIMEOUT      = 2000;
  localparam int         NUM_CASES    = 5;
  localparam logic [1:0] MODE_PLAIN   = 2'd0;
  localparam logic [1:0] MODE_BUSY_WR = 2'd1;
  localparam logic [1:0] MODE_EXT     = 2'd2;

  typedef struct packed {
    logic [DATA_W-1:0] src;
    logic [DATA_W-1:0] dst;
    logic [DATA_W-1:0] len;
    logic [DATA_W-1:0] status;
    logic [1:0]        mode;
  } copy_case_t;

  // Source, destination, length, final status, extra traffic
  copy_case_t cases [NUM_CASES] = '{
    '{32'h000, 32'h100, 32'd4, 32'h2, MODE_PLAIN},
    '{32'h040, 32'h180, 32'd8, 32'h2, MODE_BUSY_WR},
    '{32'h020, 32'h140, 32'd0, 32'h2, MODE_PLAIN},
    '{32'h080, 32'h0c0, 32'd6, 32'h2, MODE_EXT},
    '{32'h1f8, 32'h000, 32'd2, 32'h2, MODE_PLAIN}
  };

  logic                clk;
  logic                reset;
  logic                reg_valid;
  logic                reg_wr;
  logic [REG_AW-1:0]   reg_addr;
  logic [DATA_W-1:0]   reg_wdata;
  logic [DATA_W-1:0]   reg_rdata;
  logic                reg_ready;
  logic                mem_req;
  logic                mem_we;
  logic [DATA_W/8-1:0] mem_be;
  logic [DATA_W-1:0]   mem_addr;
  logic [DATA_W-1:0]   mem_wdata;
  logic                mem_gnt;
  logic                mem_rvalid;
  logic [DATA_W-1:0]   mem_rdata;
  logic                copy_intr;

  logic [DATA_W-1:0]   shadow [MEM_WORDS];
  int                  seed;
  int                  word_errors;
  int                  status_errors;
  int                  bit_errors;

  memcopy_subsystem u_dut (
    .clk_i        (clk),
    .reset_i      (reset),
    .reg_valid_i  (reg_valid),
    .reg_write_i  (reg_wr),
    .reg_addr_i   (reg_addr),
    .reg_wdata_i  (reg_wdata),
    .reg_rdata_o  (reg_rdata),
    .reg_ready_o  (reg_ready),
    .mem_req_i    (mem_req),
    .mem_we_i     (mem_we),
    .mem_be_i     (mem_be),
    .mem_addr_i   (mem_addr),
    .mem_wdata_i  (mem_wdata),
    .mem_gnt_o    (mem_gnt),
    .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o  (mem_rdata),
    .copy_intr_o  (copy_intr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_on_timeout(input string what);
    $display("timeout: %s did not complete in %0d cycles", what, TIMEOUT);
    $display("errors: word=%0d status=%0d bit=%0d", word_errors, status_errors, bit_errors);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      word_errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_status(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      status_errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // All bus tasks start and end 1 ns after a rising edge
  task automatic reg_access(input logic write, input logic [REG_AW-1:0] addr,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    int cycles;
    reg_valid = 1'b1;
    reg_wr    = write;
    reg_addr  = addr;
    reg_wdata = wdata;
    cycles    = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!reg_ready && cycles < TIMEOUT);
    if (!reg_ready) abort_on_timeout("register access");
    rdata = reg_rdata;
    #1;
    reg_valid = 1'b0;
    reg_wr    = 1'b0;
  endtask

  task automatic reg_write(input logic [REG_AW-1:0] addr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] unused;
    reg_access(1'b1, addr, data, unused);
  endtask

  task automatic reg_read(input logic [REG_AW-1:0] addr, output logic [DATA_W-1:0] data);
    reg_access(1'b0, addr, '0, data);
  endtask

  task automatic mem_access(input logic we, input logic [DATA_W/8-1:0] be,
                            input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata);
    int cycles;
    mem_req   = 1'b1;
    mem_we    = we;
    mem_be    = be;
    mem_addr  = addr;
    mem_wdata = wdata;
    cycles    = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!mem_gnt && cycles < TIMEOUT);
    if (!mem_gnt) abort_on_timeout("memory port grant");
    #1;
    mem_req = 1'b0;
    mem_we  = 1'b0;
    cycles  = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!mem_rvalid && cycles < TIMEOUT);
    if (!mem_rvalid) abort_on_timeout("memory port response");
    rdata = mem_rdata;
    #1;
  endtask

  task automatic mem_write(input logic [DATA_W-1:0] addr, input logic [DATA_W/8-1:0] be,
                           input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] unused;
    mem_access(1'b1, be, addr, data, unused);
  endtask

  task automatic mem_read(input logic [DATA_W-1:0] addr, output logic [DATA_W-1:0] data);
    mem_access(1'b0, '1, addr, '0, data);
  endtask

  task automatic wait_intr();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!copy_intr && cycles < TIMEOUT);
    if (!copy_intr) abort_on_timeout("copy completion interrupt");
    #1;
  endtask

  task automatic verify_memory();
    logic [DATA_W-1:0] rd;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_read(DATA_W'(i * 4), rd);
      check_word($sformatf("mem_rdata_o word %0d", i), rd, shadow[i]);
    end
  endtask

  task automatic run_copy(input copy_case_t cc);
    logic [DATA_W-1:0] rd;
    int                src_w;
    int                dst_w;
    src_w = int'(cc.src[MEM_AW+1:2]);
    dst_w = int'(cc.dst[MEM_AW+1:2]);
    reg_write(REG_SRC, cc.src);
    reg_write(REG_DST, cc.dst);
    reg_write(REG_LEN, cc.len);
    reg_write(REG_CTRL, 32'h1);
    check_bit("copy_intr_o", copy_intr, 1'b0);
    if (cc.len != 0) begin
      reg_read(REG_STATUS, rd);
      check_status("reg_rdata_o status", rd, DATA_W'(1) << STATUS_BUSY);
    end
    if (cc.mode == MODE_BUSY_WR) begin
      reg_write(REG_SRC, 32'h000);
      reg_write(REG_DST, 32'h1c0);
      reg_write(REG_LEN, 32'd2);
      reg_write(REG_CTRL, 32'h1);
    end
    // Words outside this copy
    // The port may stall until the engine is done
    if (cc.mode == MODE_EXT) begin
      mem_read(32'h028, rd);
      check_word("mem_rdata_o word 10", rd, shadow[10]);
      mem_read(32'h1e0, rd);
      check_word("mem_rdata_o word 120", rd, shadow[120]);
    end
    wait_intr();
    reg_read(REG_STATUS, rd);
    check_status("reg_rdata_o status", rd, cc.status);
    check_bit("copy_intr_o", copy_intr, 1'b0);
    if (cc.mode == MODE_BUSY_WR) begin
      reg_read(REG_SRC, rd);
      check_word("reg_rdata_o src", rd, cc.src);
    end
    for (int k = 0; k < int'(cc.len); k++) begin
      shadow[dst_w + k] = shadow[src_w + k];
    end
    verify_memory();
  endtask

  initial begin
    logic [DATA_W-1:0]   wr;
    logic [DATA_W/8-1:0] be;
    seed          = 32'h345b3e40;
    word_errors   = 0;
    status_errors = 0;
    bit_errors    = 0;
    reset         = 1'b1;
    reg_valid     = 1'b0;
    reg_wr        = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    mem_req       = 1'b0;
    mem_we        = 1'b0;
    mem_be        = '0;
    mem_addr      = '0;
    mem_wdata     = '0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    for (int i = 0; i < MEM_WORDS; i++) begin
      wr = $random(seed);
      mem_write(DATA_W'(i * 4), '1, wr);
      shadow[i] = wr;
    end
    // Partial writes with every byte-enable pattern once
    for (int i = 0; i < 16; i++) begin
      wr = $random(seed);
      be = 4'(i);
      mem_write(DATA_W'(i * 4), be, wr);
      for (int b = 0; b < DATA_W / 8; b++) begin
        if (be[b]) shadow[i][8*b+:8] = wr[8*b+:8];
      end
    end
    verify_memory();

    for (int c = 0; c < NUM_CASES; c++) begin
      run_copy(cases[c]);
    end

    $display("errors: word=%0d status=%0d bit=%0d", word_errors, status_errors, bit_errors);
    if (word_errors + status_errors + bit_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: memcopy_subsystem.f
src/memcopy_pkg.sv
src/obi_bus_if.sv
src/copy_counter.sv
src/memcopy_regs.sv
src/memcopy_fsm.sv
src/obi_arbiter.sv
src/slow_memory.sv
src/memcopy_subsystem.sv
tb/memcopy_subsystem_checker.sv
tb/memcopy_subsystem_tb.sv
